//--- design/ao_periph_pkg.sv
// Always-on peripheral package
// OBI and register-bus structs, peripheral address map, register offsets

package ao_periph_pkg;

  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } obi_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic        err;
    logic [31:0] rdata;
  } obi_resp_t;

  typedef struct packed {
    logic        valid;
    logic        write;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } reg_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        error;
  } reg_rsp_t;

  // Peripheral select lives in address bits 15:12
  localparam int unsigned NUM_PERIPH = 3;
  localparam int unsigned SEL_WIDTH  = 2;

  localparam int unsigned SOC_CTRL_IDX  = 0;
  localparam int unsigned FAST_INTR_IDX = 1;
  localparam int unsigned GPIO_IDX      = 2;

  localparam logic [3:0] SOC_CTRL_EXIT_VALID = 4'h0;
  localparam logic [3:0] SOC_CTRL_EXIT_VALUE = 4'h4;
  localparam logic [3:0] SOC_CTRL_BOOT       = 4'h8;
  localparam logic [3:0] SOC_CTRL_SCRATCH    = 4'hC;

  localparam logic [3:0] FAST_INTR_PENDING = 4'h0;
  localparam logic [3:0] FAST_INTR_ENABLE  = 4'h4;

  localparam logic [3:0] GPIO_IN          = 4'h0;
  localparam logic [3:0] GPIO_OUT         = 4'h4;
  localparam logic [3:0] GPIO_OUT_EN      = 4'h8;
  localparam logic [3:0] GPIO_INTR_STATUS = 4'hC;

  localparam int unsigned NUM_FAST_INTR = 15;
  localparam int unsigned NUM_GPIO      = 8;

  // Expand byte strobes into a bit mask
  function automatic logic [31:0] strb_to_mask(logic [3:0] strb);
    logic [31:0] mask;
    for (int b = 0; b < 4; b++) begin
      mask[b*8+:8] = {8{strb[b]}};
    end
    return mask;
  endfunction

endpackage : ao_periph_pkg

//--- design/ao_peripheral_subsystem.sv
// Always-on peripheral subsystem
// OBI slave port bridged to SoC control, fast interrupt and GPIO registers

module ao_peripheral_subsystem
  import ao_periph_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_n_i,

  input  obi_req_t                 slave_req_i,
  output obi_resp_t                slave_resp_o,

  input  logic                     boot_select_i,
  input  logic                     execute_from_flash_i,
  output logic                     exit_valid_o,
  output logic [31:0]              exit_value_o,

  input  logic [NUM_FAST_INTR-1:0] fast_intr_i,
  output logic [NUM_FAST_INTR-1:0] fast_intr_o,

  input  logic [NUM_GPIO-1:0]      cio_gpio_i,
  output logic [NUM_GPIO-1:0]      cio_gpio_o,
  output logic [NUM_GPIO-1:0]      cio_gpio_en_o,
  output logic [NUM_GPIO-1:0]      intr_gpio_o
);

  reg_req_t                  periph_req;
  reg_rsp_t                  periph_rsp;
  reg_req_t [NUM_PERIPH-1:0] slv_req;
  reg_rsp_t [NUM_PERIPH-1:0] slv_rsp;

  obi_to_reg u_obi_to_reg (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .obi_req_i  (slave_req_i),
    .obi_resp_o (slave_resp_o),
    .reg_req_o  (periph_req),
    .reg_rsp_i  (periph_rsp)
  );

  reg_demux u_reg_demux (
    .reg_req_i    (periph_req),
    .reg_rsp_o    (periph_rsp),
    .periph_req_o (slv_req),
    .periph_rsp_i (slv_rsp)
  );

  soc_ctrl u_soc_ctrl (
    .clk_i                (clk_i),
    .rst_n_i              (rst_n_i),
    .reg_req_i            (slv_req[SOC_CTRL_IDX]),
    .reg_rsp_o            (slv_rsp[SOC_CTRL_IDX]),
    .boot_select_i        (boot_select_i),
    .execute_from_flash_i (execute_from_flash_i),
    .exit_valid_o         (exit_valid_o),
    .exit_value_o         (exit_value_o)
  );

  fast_intr_ctrl u_fast_intr_ctrl (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .reg_req_i   (slv_req[FAST_INTR_IDX]),
    .reg_rsp_o   (slv_rsp[FAST_INTR_IDX]),
    .fast_intr_i (fast_intr_i),
    .fast_intr_o (fast_intr_o)
  );

  gpio u_gpio (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .reg_req_i     (slv_req[GPIO_IDX]),
    .reg_rsp_o     (slv_rsp[GPIO_IDX]),
    .cio_gpio_i    (cio_gpio_i),
    .cio_gpio_o    (cio_gpio_o),
    .cio_gpio_en_o (cio_gpio_en_o),
    .intr_gpio_o   (intr_gpio_o)
  );

endmodule : ao_peripheral_subsystem

//--- design/fast_intr_ctrl.sv
// Fast interrupt controller
// Sticky pending bits with write-1-to-clear, masked by an enable register

module fast_intr_ctrl
  import ao_periph_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  reg_req_t                 reg_req_i,
  output reg_rsp_t                 reg_rsp_o,
  input  logic [NUM_FAST_INTR-1:0] fast_intr_i,
  output logic [NUM_FAST_INTR-1:0] fast_intr_o
);

  logic [3:0]               offset;
  logic                     wr_en;
  logic [31:0]              wmask;
  logic [NUM_FAST_INTR-1:0] clear;

  logic [NUM_FAST_INTR-1:0] pending_q;
  logic [NUM_FAST_INTR-1:0] enable_q;

  assign offset = {reg_req_i.addr[3:2], 2'b00};
  assign wr_en  = reg_req_i.valid & reg_req_i.write;
  assign wmask  = strb_to_mask(reg_req_i.wstrb);

  always_comb begin
    clear = '0;
    if (wr_en && offset == FAST_INTR_PENDING) begin
      clear = reg_req_i.wdata[NUM_FAST_INTR-1:0] & wmask[NUM_FAST_INTR-1:0];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pending_q <= '0;
      enable_q  <= '0;
    end else begin
      // A line high in the clearing cycle keeps its bit
      pending_q <= (pending_q & ~clear) | fast_intr_i;
      if (wr_en && offset == FAST_INTR_ENABLE) begin
        enable_q <= (enable_q & ~wmask[NUM_FAST_INTR-1:0]) |
                    (reg_req_i.wdata[NUM_FAST_INTR-1:0] & wmask[NUM_FAST_INTR-1:0]);
      end
    end
  end

  always_comb begin
    reg_rsp_o.error = 1'b0;
    case (offset)
      FAST_INTR_PENDING: reg_rsp_o.rdata = 32'(pending_q);
      FAST_INTR_ENABLE:  reg_rsp_o.rdata = 32'(enable_q);
      default:           reg_rsp_o.rdata = 32'h0;
    endcase
  end

  assign fast_intr_o = pending_q & enable_q;

endmodule : fast_intr_ctrl

//--- design/gpio.sv
// GPIO block for 8 pins
// Synchronized inputs, output and enable registers, rising-edge interrupts

module gpio
  import ao_periph_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  reg_req_t            reg_req_i,
  output reg_rsp_t            reg_rsp_o,
  input  logic [NUM_GPIO-1:0] cio_gpio_i,
  output logic [NUM_GPIO-1:0] cio_gpio_o,
  output logic [NUM_GPIO-1:0] cio_gpio_en_o,
  output logic [NUM_GPIO-1:0] intr_gpio_o
);

  logic [3:0]          offset;
  logic                wr_en;
  logic [NUM_GPIO-1:0] wmask;
  logic [NUM_GPIO-1:0] wdata;
  logic [NUM_GPIO-1:0] clear;
  logic [NUM_GPIO-1:0] rise;

  logic [NUM_GPIO-1:0] sync1_q;
  logic [NUM_GPIO-1:0] sync2_q;
  logic [NUM_GPIO-1:0] delay_q;
  logic [NUM_GPIO-1:0] out_q;
  logic [NUM_GPIO-1:0] out_en_q;
  logic [NUM_GPIO-1:0] intr_q;

  assign offset = {reg_req_i.addr[3:2], 2'b00};
  assign wr_en  = reg_req_i.valid & reg_req_i.write;
  assign wmask  = NUM_GPIO'(strb_to_mask(reg_req_i.wstrb));
  assign wdata  = reg_req_i.wdata[NUM_GPIO-1:0];

  assign rise  = sync2_q & ~delay_q;
  assign clear = (wr_en && offset == GPIO_INTR_STATUS) ? (wdata & wmask) : '0;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync1_q  <= '0;
      sync2_q  <= '0;
      delay_q  <= '0;
      out_q    <= '0;
      out_en_q <= '0;
      intr_q   <= '0;
    end else begin
      sync1_q <= cio_gpio_i;
      sync2_q <= sync1_q;
      delay_q <= sync2_q;
      // New edge wins over a clear in the same cycle
      intr_q  <= (intr_q & ~clear) | rise;
      if (wr_en && offset == GPIO_OUT) begin
        out_q <= (out_q & ~wmask) | (wdata & wmask);
      end
      if (wr_en && offset == GPIO_OUT_EN) begin
        out_en_q <= (out_en_q & ~wmask) | (wdata & wmask);
      end
    end
  end

  always_comb begin
    reg_rsp_o.error = 1'b0;
    case (offset)
      GPIO_IN:          reg_rsp_o.rdata = 32'(sync2_q);
      GPIO_OUT:         reg_rsp_o.rdata = 32'(out_q);
      GPIO_OUT_EN:      reg_rsp_o.rdata = 32'(out_en_q);
      GPIO_INTR_STATUS: reg_rsp_o.rdata = 32'(intr_q);
      default:          reg_rsp_o.rdata = 32'h0;
    endcase
  end

  assign cio_gpio_o    = out_q;
  assign cio_gpio_en_o = out_en_q;
  assign intr_gpio_o   = intr_q;

endmodule : gpio

//--- design/obi_to_reg.sv
// OBI to register-bus bridge
// Stage one turns an accepted request into a strobe, stage two returns rvalid

module obi_to_reg
  import ao_periph_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  obi_req_t  obi_req_i,
  output obi_resp_t obi_resp_o,
  output reg_req_t  reg_req_o,
  input  reg_rsp_t  reg_rsp_i
);

  logic        gnt_q;
  logic        accepted;

  logic        valid_q;
  logic        write_q;
  logic [31:0] addr_q;
  logic [31:0] wdata_q;
  logic [3:0]  wstrb_q;

  logic        rvalid_q;
  logic        err_q;
  logic [31:0] rdata_q;

  assign accepted = obi_req_i.req & gnt_q;

  // Grant comes up one cycle after reset release
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      gnt_q    <= 1'b0;
      valid_q  <= 1'b0;
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      gnt_q    <= 1'b1;
      valid_q  <= accepted;
      rvalid_q <= valid_q;
      err_q    <= valid_q & reg_rsp_i.error;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accepted) begin
      write_q <= obi_req_i.we;
      addr_q  <= obi_req_i.addr;
      wdata_q <= obi_req_i.wdata;
      wstrb_q <= obi_req_i.be;
    end
  end

  // Writes return zero data
  always_ff @(posedge clk_i) begin
    if (valid_q) begin
      rdata_q <= write_q ? 32'h0 : reg_rsp_i.rdata;
    end
  end

  assign reg_req_o = '{valid: valid_q, write: write_q, addr: addr_q,
                       wdata: wdata_q, wstrb: wstrb_q};

  assign obi_resp_o = '{gnt: gnt_q, rvalid: rvalid_q, err: err_q, rdata: rdata_q};

  // Every accepted request answers two edges later, and only then
  a_rvalid_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    obi_resp_o.rvalid == $past(accepted, 2));

endmodule : obi_to_reg

//--- design/reg_demux.sv
// Register-bus demultiplexer
// Routes the strobe by address bits 15:12, flags unmapped peripherals

module reg_demux
  import ao_periph_pkg::*;
(
  input  reg_req_t                  reg_req_i,
  output reg_rsp_t                  reg_rsp_o,
  output reg_req_t [NUM_PERIPH-1:0] periph_req_o,
  input  reg_rsp_t [NUM_PERIPH-1:0] periph_rsp_i
);

  logic [3:0]           field;
  logic                 in_range;
  logic [SEL_WIDTH-1:0] sel;
  logic [NUM_PERIPH-1:0] valid_vec;

  assign field    = reg_req_i.addr[15:12];
  assign in_range = (field < 4'(NUM_PERIPH));
  assign sel      = field[SEL_WIDTH-1:0];

  always_comb begin
    for (int i = 0; i < NUM_PERIPH; i++) begin
      periph_req_o[i]       = reg_req_i;
      valid_vec[i]          = reg_req_i.valid & in_range & (sel == SEL_WIDTH'(i));
      periph_req_o[i].valid = valid_vec[i];
    end
  end

  // Unmapped field answers with an error and no data
  always_comb begin
    if (in_range) begin
      reg_rsp_o = periph_rsp_i[sel];
    end else begin
      reg_rsp_o.rdata = 32'h0;
      reg_rsp_o.error = 1'b1;
    end
  end

  always_comb begin
    a_one_slave: assert ($onehot0(valid_vec));
  end

endmodule : reg_demux

//--- design/soc_ctrl.sv
// SoC control registers
// Exit valid/value, boot-mode status and a scratch word

module soc_ctrl
  import ao_periph_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  reg_req_t    reg_req_i,
  output reg_rsp_t    reg_rsp_o,
  input  logic        boot_select_i,
  input  logic        execute_from_flash_i,
  output logic        exit_valid_o,
  output logic [31:0] exit_value_o
);

  logic [3:0]  offset;
  logic        wr_en;
  logic [31:0] wmask;

  logic        exit_valid_q;
  logic [31:0] exit_value_q;
  logic [31:0] scratch_q;

  assign offset = {reg_req_i.addr[3:2], 2'b00};
  assign wr_en  = reg_req_i.valid & reg_req_i.write;
  assign wmask  = strb_to_mask(reg_req_i.wstrb);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= 32'h0;
      scratch_q    <= 32'h0;
    end else if (wr_en) begin
      if (offset == SOC_CTRL_EXIT_VALID && reg_req_i.wstrb[0]) begin
        exit_valid_q <= reg_req_i.wdata[0];
      end
      if (offset == SOC_CTRL_EXIT_VALUE) begin
        exit_value_q <= (exit_value_q & ~wmask) | (reg_req_i.wdata & wmask);
      end
      if (offset == SOC_CTRL_SCRATCH) begin
        scratch_q <= (scratch_q & ~wmask) | (reg_req_i.wdata & wmask);
      end
    end
  end

  always_comb begin
    reg_rsp_o.error = 1'b0;
    case (offset)
      SOC_CTRL_EXIT_VALID: reg_rsp_o.rdata = {31'h0, exit_valid_q};
      SOC_CTRL_EXIT_VALUE: reg_rsp_o.rdata = exit_value_q;
      // Read-only boot mode straps
      SOC_CTRL_BOOT:       reg_rsp_o.rdata = {30'h0, execute_from_flash_i, boot_select_i};
      SOC_CTRL_SCRATCH:    reg_rsp_o.rdata = scratch_q;
      default:             reg_rsp_o.rdata = 32'h0;
    endcase
  end

  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

endmodule : soc_ctrl

//--- list.f
+incdir+tests
design/ao_periph_pkg.sv
design/obi_to_reg.sv
design/reg_demux.sv
design/soc_ctrl.sv
design/fast_intr_ctrl.sv
design/gpio.sv
design/ao_peripheral_subsystem.sv
tests/tb_ao_peripheral_subsystem.sv

//--- run.sh
#!/bin/sh
# Build and run the always-on peripheral testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f list.f \
  --top-module tb_ao_peripheral_subsystem \
  -Mdir obj_dir \
  -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "^PASS: all tests$" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation did not pass, see sim.log"
  exit 1
fi

//--- tests/tb_ao_model.svh
// Cycle model of the always-on peripheral subsystem
// Register mirrors, strobe stage and GPIO synchronizer stepped once per clock edge

`ifndef TB_AO_MODEL_SVH
`define TB_AO_MODEL_SVH

logic        m_gnt;
logic        m_exit_valid;
logic [31:0] m_exit_value;
logic [31:0] m_scratch;
logic [14:0] m_pending;
logic [14:0] m_enable;
logic [7:0]  m_sync1;
logic [7:0]  m_sync2;
logic [7:0]  m_delay;
logic [7:0]  m_out;
logic [7:0]  m_out_en;
logic [7:0]  m_intr;
// Request from the last edge with req set only when it was accepted
obi_req_t    m_strobe;

function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wdata,
                                            input logic [3:0] be);
  logic [31:0] m;
  m = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
  return (old & ~m) | (wdata & m);
endfunction

// Returns {err, rdata} for a read in the current strobe cycle
function automatic logic [32:0] expected_read(input logic [31:0] addr, input logic bsel,
                                              input logic xflash);
  logic [31:0] d;
  d = 32'h0;
  case (addr[15:12])
    4'd0: begin
      case (addr[3:2])
        2'd0:    d = {31'h0, m_exit_valid};
        2'd1:    d = m_exit_value;
        2'd2:    d = {30'h0, xflash, bsel};
        default: d = m_scratch;
      endcase
    end
    4'd1: begin
      if (addr[3:2] == 2'd0) begin
        d = 32'(m_pending);
      end else if (addr[3:2] == 2'd1) begin
        d = 32'(m_enable);
      end
    end
    4'd2: begin
      case (addr[3:2])
        2'd0:    d = 32'(m_sync2);
        2'd1:    d = 32'(m_out);
        2'd2:    d = 32'(m_out_en);
        default: d = 32'(m_intr);
      endcase
    end
    default: return {1'b1, 32'h0};
  endcase
  return {1'b0, d};
endfunction

task automatic advance_model(input logic rst, input obi_req_t bus, input logic [14:0] fast,
                             input logic [7:0] pins, input logic bsel, input logic xflash,
                             output logic has_rsp, output logic [32:0] rsp);
  logic [14:0] clr_pend;
  logic [7:0]  clr_intr;
  logic [31:0] wclr;
  has_rsp  = 1'b0;
  rsp      = '0;
  clr_pend = '0;
  clr_intr = '0;
  if (!rst) begin
    m_gnt        = 1'b0;
    m_exit_valid = 1'b0;
    m_exit_value = '0;
    m_scratch    = '0;
    m_pending    = '0;
    m_enable     = '0;
    m_sync1      = '0;
    m_sync2      = '0;
    m_delay      = '0;
    m_out        = '0;
    m_out_en     = '0;
    m_intr       = '0;
    m_strobe     = '0;
  end else begin
    if (m_strobe.req) begin
      has_rsp = 1'b1;
      rsp     = expected_read(m_strobe.addr, bsel, xflash);
      if (m_strobe.we) begin
        rsp[31:0] = 32'h0;
        wclr      = merge_bytes(32'h0, m_strobe.wdata, m_strobe.be);
        // Key is {peripheral field, word index}
        case ({m_strobe.addr[15:12], m_strobe.addr[3:2]})
          6'h00: begin
            if (m_strobe.be[0]) begin
              m_exit_valid = m_strobe.wdata[0];
            end
          end
          6'h01: m_exit_value = merge_bytes(m_exit_value, m_strobe.wdata, m_strobe.be);
          6'h03: m_scratch = merge_bytes(m_scratch, m_strobe.wdata, m_strobe.be);
          6'h04: clr_pend = wclr[14:0];
          6'h05: m_enable = 15'(merge_bytes(32'(m_enable), m_strobe.wdata, m_strobe.be));
          6'h09: m_out = 8'(merge_bytes(32'(m_out), m_strobe.wdata, m_strobe.be));
          6'h0A: m_out_en = 8'(merge_bytes(32'(m_out_en), m_strobe.wdata, m_strobe.be));
          6'h0B: clr_intr = wclr[7:0];
          default: ;
        endcase
      end
    end
    // Set wins over a clear in the same cycle
    m_pending    = (m_pending & ~clr_pend) | fast;
    m_intr       = (m_intr & ~clr_intr) | (m_sync2 & ~m_delay);
    m_delay      = m_sync2;
    m_sync2      = m_sync1;
    m_sync1      = pins;
    m_strobe     = bus;
    m_strobe.req = bus.req & m_gnt;
    m_gnt        = 1'b1;
  end
endtask

`endif

//--- tests/tb_ao_peripheral_subsystem.sv
// Testbench for the always-on peripheral subsystem
// Random OBI traffic and pin stimulus checked every cycle against a reference model

module tb_ao_peripheral_subsystem
  import ao_periph_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYCLES = 4;
  localparam int RAND_OPS     = 400;
  localparam int UNMAPPED_OPS = 40;
  localparam int BOOT_ROUNDS  = 30;
  localparam int FAST_CYCLES  = 200;
  localparam int GPIO_ROUNDS  = 40;
  // Twice the longest possible run of all phases
  localparam int MAX_CYCLES = 2 * (RESET_CYCLES + RAND_OPS + UNMAPPED_OPS + 3 * BOOT_ROUNDS +
                                   FAST_CYCLES + 10 * GPIO_ROUNDS + 20);

  logic        clk;
  logic        rst_n;
  obi_req_t    req;
  obi_resp_t   resp;
  logic        boot_sel;
  logic        exec_flash;
  logic        exit_valid;
  logic [31:0] exit_value;
  logic [14:0] fast_in;
  logic [14:0] fast_out;
  logic [7:0]  gpio_in;
  logic [7:0]  gpio_out;
  logic [7:0]  gpio_en;
  logic [7:0]  gpio_intr;

  logic [15:0] lfsr_q;
  int          cycles = 0;
  int          n_checks;
  int          n_mismatch;
  int          n_other;
  logic [32:0] exp_q[$];

  `include "tb_ao_model.svh"

  ao_peripheral_subsystem u_ao_peripheral_subsystem (
    .clk_i                (clk),
    .rst_n_i              (rst_n),
    .slave_req_i          (req),
    .slave_resp_o         (resp),
    .boot_select_i        (boot_sel),
    .execute_from_flash_i (exec_flash),
    .exit_valid_o         (exit_valid),
    .exit_value_o         (exit_value),
    .fast_intr_i          (fast_in),
    .fast_intr_o          (fast_out),
    .cio_gpio_i           (gpio_in),
    .cio_gpio_o           (gpio_out),
    .cio_gpio_en_o        (gpio_en),
    .intr_gpio_o          (gpio_intr)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, the test sequence did not finish", cycles);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] rw_address(input int k);
    case (k)
      0:       return 32'h0000_0000;
      1:       return 32'h0000_0004;
      2:       return 32'h0000_000C;
      3:       return 32'h0000_1004;
      4:       return 32'h0000_2004;
      default: return 32'h0000_2008;
    endcase
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_mismatch++;
      $display("mismatch at %0t: %s expected %h got %h", $time, what, exp, got);
    end
  endtask

  // Advance the model one clock, check rvalid and pins, then drop one-cycle inputs
  task automatic step_cycle();
    logic        has_rsp;
    logic [32:0] rsp;
    logic [32:0] head;
    @(posedge clk);
    #1;
    advance_model(rst_n, req, fast_in, gpio_in, boot_sel, exec_flash, has_rsp, rsp);
    if (has_rsp) begin
      exp_q.push_back(rsp);
    end
    if (resp.rvalid) begin
      if (exp_q.size() == 0) begin
        n_other++;
        $display("rvalid at %0t without an accepted request", $time);
      end else begin
        head = exp_q.pop_front();
        check_value("rsp err", 32'(resp.err), 32'(head[32]));
        check_value("rsp rdata", resp.rdata, head[31:0]);
      end
    end else if (exp_q.size() != 0) begin
      void'(exp_q.pop_front());
      n_other++;
      $display("no rvalid at %0t, two edges after an accepted request", $time);
    end
    check_value("gnt", 32'(resp.gnt), 32'(m_gnt));
    check_value("exit_valid_o", 32'(exit_valid), 32'(m_exit_valid));
    check_value("exit_value_o", exit_value, m_exit_value);
    check_value("fast_intr_o", 32'(fast_out), 32'(m_pending & m_enable));
    check_value("cio_gpio_o", 32'(gpio_out), 32'(m_out));
    check_value("cio_gpio_en_o", 32'(gpio_en), 32'(m_out_en));
    check_value("intr_gpio_o", 32'(gpio_intr), 32'(m_intr));
    req.req = 1'b0;
    fast_in = '0;
  endtask

  task automatic issue(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                       input logic [3:0] be);
    req.req   = 1'b1;
    req.we    = we;
    req.be    = be;
    req.addr  = addr;
    req.wdata = wdata;
    step_cycle();
  endtask

  task automatic random_access(input logic [31:0] addr);
    logic        we;
    logic [31:0] wdata;
    logic [3:0]  be;
    we    = 1'(take_bits(1));
    wdata = take_bits(32);
    be    = 4'(take_bits(4));
    issue(we, addr, wdata, be);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) step_cycle();
  endtask

  initial begin
    int         op;
    int         hold;
    logic [3:0] field;
    rst_n      = 1'b0;
    req        = '0;
    boot_sel   = 1'b0;
    exec_flash = 1'b0;
    fast_in    = '0;
    gpio_in    = '0;
    lfsr_q     = 16'd90;
    n_checks   = 0;
    n_mismatch = 0;
    n_other    = 0;

    idle_cycles(RESET_CYCLES);
    rst_n = 1'b1;
    idle_cycles(2);

    // Back-to-back traffic keeps two transfers in flight
    for (int i = 0; i < RAND_OPS; i++) begin
      random_access(rw_address(int'(take_bits(3) % 6)));
    end

    for (int i = 0; i < UNMAPPED_OPS; i++) begin
      field = 4'(3 + take_bits(4) % 13);
      random_access({16'h0, field, 8'h0, 2'(take_bits(2)), 2'b00});
    end
    for (int k = 0; k < 6; k++) begin
      issue(1'b0, rw_address(k), 32'h0, 4'hF);
    end

    for (int i = 0; i < BOOT_ROUNDS; i++) begin
      boot_sel   = 1'(take_bits(1));
      exec_flash = 1'(take_bits(1));
      issue(1'b0, 32'h8, 32'h0, 4'hF);
      issue(1'b1, 32'h8, take_bits(32), 4'hF);
      issue(1'b0, 32'h8, 32'h0, 4'hF);
    end

    issue(1'b1, 32'h1004, take_bits(32), 4'hF);
    for (int i = 0; i < FAST_CYCLES; i++) begin
      // Sparse single-cycle pulses
      fast_in = 15'(take_bits(15) & take_bits(15));
      op      = int'(take_bits(2));
      case (op)
        0:       random_access(32'h1000);
        1:       random_access(32'h1004);
        2:       issue(1'b0, 32'h1000, 32'h0, 4'hF);
        default: step_cycle();
      endcase
    end

    for (int i = 0; i < GPIO_ROUNDS; i++) begin
      gpio_in = 8'(take_bits(8));
      hold    = 6 + int'(take_bits(2));
      for (int c = 0; c < hold; c++) begin
        op = int'(take_bits(2));
        case (op)
          0:       issue(1'b0, 32'h2000, 32'h0, 4'hF);
          1:       issue(1'b0, 32'h200C, 32'h0, 4'hF);
          2:       random_access(32'h200C);
          default: step_cycle();
        endcase
      end
      issue(1'b0, 32'h2000, 32'h0, 4'hF);
    end

    idle_cycles(4);
    $display("checks %0d, mismatches %0d, other errors %0d", n_checks, n_mismatch, n_other);
    if (n_mismatch == 0 && n_other == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule : tb_ao_peripheral_subsystem
